// File: source/zports_pkg.sv
/* shared definitions of the z80 port block
   port numbers, bus types, strobe and register structs, reset values */
package zports_pkg;

	//////////////////////////////////////////////////////////////////////
	// bus types
	typedef logic [7:0]  data_t;    // z80 data byte
	typedef logic [15:0] addr_t;    // z80 address bus
	typedef logic [7:0]  port_lo_t; // low address byte selects the port
	typedef logic [4:0]  be_idx_t;  // a[12:8] on xxBE reads

	//////////////////////////////////////////////////////////////////////
	// port numbers, low byte only
	localparam port_lo_t PORT_FE     = 8'hFE; // keyboard, tape in, border
	localparam port_lo_t PORT_F6     = 8'hF6; // alias of FE without beeper
	localparam port_lo_t PORT_FD     = 8'hFD; // 7FFD paging, BFFD/FFFD ay
	localparam port_lo_t PORT_F7     = 8'hF7; // EFF7 paging
	localparam port_lo_t PORT_KJOY   = 8'h1F; // kempston joystick
	localparam port_lo_t PORT_KMOUSE = 8'hDF; // kempston mouse
	localparam port_lo_t PORT_CFG    = 8'hBF; // config register
	localparam port_lo_t PORT_CFGRD  = 8'hBE; // readback, nmi clear on write

	// readback index in a[12:8]
	localparam be_idx_t BE_IDX_7FFD = 5'h0A;
	localparam be_idx_t BE_IDX_EFF7 = 5'h0B;

	localparam data_t READ_IDLE = 8'hFF; // floating bus value

	//////////////////////////////////////////////////////////////////////
	// structs
	typedef struct packed {
		logic wr; // one cycle per write access
		logic rd; // one cycle per read access
	} io_strobe_t;

	// address and shadow qualified, strobe not included
	typedef struct packed {
		logic fe;
		logic p7ffd;
		logic eff7;
		logic cfg;
		logic cfgrd;
		logic ay_addr;
		logic ay_reg;
	} port_sel_t;

	typedef struct packed {
		data_t p7ffd; // raw, no lock masking
		data_t eff7;
	} paging_t;

	typedef struct packed {
		logic shadow_en; // bit 0 of xxBF
		logic romrw_en;  // bit 1
		logic set_nmi;   // bit 3
	} sys_cfg_t;

	// reset values
	localparam paging_t    PAGING_RST = '{p7ffd: 8'h00, eff7: 8'h00};
	localparam sys_cfg_t   CFG_RST    = '{shadow_en: 1'b0, romrw_en: 1'b0, set_nmi: 1'b0};
	localparam logic [3:0] BORDER_RST = 4'h0;

endpackage

// File: source/io_strobes.sv
/* z80 io cycle to strobe conversion
   one zclk pulse on the first cycle of every io write and io read */
module io_strobes (
	input  logic                   zclk,
	input  logic                   rst_n,
	input  logic                   iorq_n,
	input  logic                   rd_n,
	input  logic                   wr_n,
	output zports_pkg::io_strobe_t strb
);

	logic wr_act;  // write access in progress
	logic rd_act;  // read access in progress
	logic wr_seen; // write level at last edge
	logic rd_seen;

	assign wr_act = ~(iorq_n | wr_n);
	assign rd_act = ~(iorq_n | rd_n);

	// pulse only when level was low at previous edge
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_seen <= 1'b0;
			rd_seen <= 1'b0;
			strb    <= '0;
		end
		else
		begin
			wr_seen <= wr_act;
			rd_seen <= rd_act;
			strb.wr <= wr_act & ~wr_seen; // long cycles give one pulse
			strb.rd <= rd_act & ~rd_seen;
		end
	end

endmodule

// File: source/port_decoder.sv
/* port decoder of the z80 io block
   low address byte plus shadow state into hit, external and port selects */
module port_decoder (
	input  zports_pkg::addr_t     a,
	input  logic                  dos,
	input  zports_pkg::sys_cfg_t  cfg,
	output zports_pkg::port_sel_t sel,
	output logic                  porthit,
	output logic                  external_port,
	output logic                  shadow
);

	zports_pkg::port_lo_t loa; // low address byte

	logic is_fe;  // FE or F6
	logic is_fd;
	logic is_f7;
	logic is_kjoy;
	logic is_mouse;
	logic is_cfg;
	logic is_cfgrd;
	logic f7_hit; // F7 visible in current mode

	assign loa    = a[7:0];
	assign shadow = dos | cfg.shadow_en; // trdos rom or forced by xxBF

	//////////////////////////////////////////////////////////////////////
	// raw port compares
	assign is_fe    = (loa == zports_pkg::PORT_FE) || (loa == zports_pkg::PORT_F6);
	assign is_fd    = (loa == zports_pkg::PORT_FD);
	assign is_f7    = (loa == zports_pkg::PORT_F7);
	assign is_kjoy  = (loa == zports_pkg::PORT_KJOY);
	assign is_mouse = (loa == zports_pkg::PORT_KMOUSE);
	assign is_cfg   = (loa == zports_pkg::PORT_CFG);
	assign is_cfgrd = (loa == zports_pkg::PORT_CFGRD);

	// F7 moves to a8 low in shadow mode
	// keeps xFF7 free for shadow mode peripherals
	assign f7_hit = is_f7 & (a[8] ^ shadow);

	//////////////////////////////////////////////////////////////////////
	// bus level outputs
	always_comb
	begin
		porthit = is_fe | is_fd | is_cfg | is_cfgrd | is_mouse; // every mode
		if (is_kjoy && !shadow)
			porthit = 1'b1; // 1F belongs to disk ctrl in shadow
		if (f7_hit)
			porthit = 1'b1;
	end

	assign external_port = is_fd & a[15]; // ay chip drives the bus itself

	//////////////////////////////////////////////////////////////////////
	// per port selects
	always_comb
	begin
		sel.fe      = is_fe;
		sel.p7ffd   = is_fd & ~a[15];
		sel.eff7    = is_f7 & ~a[12] & a[8] & ~shadow; // EEF7 in shadow not written
		sel.cfg     = is_cfg;
		sel.cfgrd   = is_cfgrd;
		sel.ay_addr = is_fd & a[15];          // BFFD and FFFD
		sel.ay_reg  = is_fd & a[15] & a[14];  // FFFD only
	end

endmodule

// File: source/paging_regs.sv
/* 7FFD and EFF7 memory paging registers
   48k lock through 7FFD bit 5, 1 meg lock through EFF7 bit 2 */
module paging_regs (
	input  logic                  zclk,
	input  logic                  rst_n,
	input  zports_pkg::data_t     din,
	input  zports_pkg::io_strobe_t strb,
	input  zports_pkg::port_sel_t sel,
	output zports_pkg::paging_t   pg,
	output zports_pkg::data_t     p7ffd,
	output zports_pkg::data_t     peff7,
	output logic [5:0]            pent1m_page,
	output logic                  pent1m_rom,
	output logic                  pent1m_1m_on,
	output logic                  pent1m_ram0_0
);

	logic block1m;   // 128k mode, upper page bits off
	logic block7ffd; // 48k lock engaged

	assign block1m   = pg.eff7[2];
	assign block7ffd = pg.p7ffd[5] & block1m;

	//////////////////////////////////////////////////////////////////////
	// register writes
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pg <= zports_pkg::PAGING_RST;
		end
		else
		begin
			// 2..0 page, 3 screen, 4 rom, 5 lock48, 7..6 high page
			if (strb.wr && sel.p7ffd && !block7ffd)
				pg.p7ffd <= din;
			// 0 p16c, 2 block1m, 3 ram0 at 0000, 4 turbo off
			if (strb.wr && sel.eff7)
				pg.eff7 <= din;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// masked views for the rest of the machine
	always_comb
	begin
		p7ffd = pg.p7ffd;
		peff7 = pg.eff7;
		if (block1m)
		begin
			p7ffd[7:5] = 3'b000; // plain 128k paging
			peff7[6]   = 1'b0;
			peff7[3:1] = 3'b000;
		end
	end

	// pentagon 1m decode from raw bits
	assign pent1m_page   = {pg.p7ffd[7:5], pg.p7ffd[2:0]};
	assign pent1m_rom    = pg.p7ffd[4];
	assign pent1m_1m_on  = ~pg.eff7[2];
	assign pent1m_ram0_0 = pg.eff7[3];

endmodule

// File: source/system_regs.sv
/* border, beeper, xxBF config register and nmi clear
   all updated on the edge that closes the write strobe */
module system_regs (
	input  logic                   zclk,
	input  logic                   rst_n,
	input  zports_pkg::data_t      din,
	input  zports_pkg::addr_t      a,
	input  zports_pkg::io_strobe_t strb,
	input  zports_pkg::port_sel_t  sel,
	output zports_pkg::sys_cfg_t   cfg,
	output logic [3:0]             border,
	output logic                   beeper_wr,
	output logic                   clr_nmi
);

	logic fe_wr;  // FE or F6 write
	logic cfg_wr; // xxBF write

	assign fe_wr  = strb.wr & sel.fe;
	assign cfg_wr = strb.wr & sel.cfg;

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cfg       <= zports_pkg::CFG_RST;
			border    <= zports_pkg::BORDER_RST;
			beeper_wr <= 1'b0;
			clr_nmi   <= 1'b0;
		end
		else
		begin
			beeper_wr <= fe_wr && (a[7:0] == zports_pkg::PORT_FE); // F6 stays silent
			clr_nmi   <= strb.wr & sel.cfgrd; // xxBE write ends nmi

			if (fe_wr)
				border <= {~a[3], din[2:0]}; // bright bit from a3

			if (cfg_wr)
			begin
				cfg.shadow_en <= din[0];
				cfg.romrw_en  <= din[1];
				cfg.set_nmi   <= din[3];
			end
		end
	end

endmodule

// File: source/read_mux.sv
/* read data mux of the z80 port block
   byte returned for every readable port, FF elsewhere */
module read_mux (
	input  zports_pkg::addr_t    a,
	input  logic                 shadow,
	input  logic [4:0]           keys_in,
	input  logic                 tape_read,
	input  logic [4:0]           kj_in,
	input  zports_pkg::data_t    mus_in,
	input  zports_pkg::sys_cfg_t cfg,
	input  zports_pkg::paging_t  pg,
	output zports_pkg::data_t    dout
);

	zports_pkg::be_idx_t be_idx; // readback select

	assign be_idx = a[12:8];

	always_comb
	begin
		dout = zports_pkg::READ_IDLE;
		case (a[7:0])
			zports_pkg::PORT_FE, zports_pkg::PORT_F6:
				dout = {1'b1, tape_read, 1'b0, keys_in};
			zports_pkg::PORT_KJOY:
				if (!shadow)
					dout = {3'b000, kj_in}; // disk ctrl owns it in shadow
			zports_pkg::PORT_KMOUSE:
				dout = mus_in;
			zports_pkg::PORT_CFG:
				dout = {5'b00000, cfg.set_nmi, cfg.romrw_en, cfg.shadow_en};
			zports_pkg::PORT_CFGRD:
			begin
				if (be_idx == zports_pkg::BE_IDX_7FFD)
					dout = pg.p7ffd; // raw, lock not applied
				else if (be_idx == zports_pkg::BE_IDX_EFF7)
					dout = pg.eff7;
			end
			default:
				dout = zports_pkg::READ_IDLE;
		endcase
	end

endmodule

// File: source/zports.sv
/* z80 io port block top level
   strobes, decoder, paging and system registers, read mux, bus gating */
module zports (
	input  logic              zclk,
	input  logic              rst_n,
	input  zports_pkg::addr_t a,
	input  zports_pkg::data_t din,
	input  logic              iorq_n,
	input  logic              rd_n,
	input  logic              wr_n,
	input  logic              dos,
	input  logic [4:0]        keys_in,
	input  logic              tape_read,
	input  logic [4:0]        kj_in,
	input  zports_pkg::data_t mus_in,
	output zports_pkg::data_t dout,
	output logic              dataout,       // z80 bus driver enable
	output logic              porthit,
	output logic              external_port,
	output logic              ay_bdir,
	output logic              ay_bc1,
	output logic [3:0]        border,
	output logic              beeper_wr,
	output logic              clr_nmi,
	output logic              romrw_en,
	output logic              set_nmi,
	output zports_pkg::data_t p7ffd,
	output zports_pkg::data_t peff7,
	output logic [5:0]        pent1m_page,
	output logic              pent1m_rom,
	output logic              pent1m_1m_on,
	output logic              pent1m_ram0_0
);

	zports_pkg::io_strobe_t strb;
	zports_pkg::port_sel_t  sel;
	zports_pkg::sys_cfg_t   cfg;
	zports_pkg::paging_t    pg;
	logic                   shadow;
	logic                   io_rd; // io read in progress
	logic                   io_wr;

	//////////////////////////////////////////////////////////////////////
	// bus side gating, straight from z80 controls
	assign io_rd   = ~iorq_n & ~rd_n;
	assign io_wr   = ~iorq_n & ~wr_n;
	assign dataout = porthit & io_rd & ~external_port; // ay answers itself
	assign ay_bc1  = sel.ay_reg & (io_rd | io_wr);
	assign ay_bdir = sel.ay_addr & io_wr;

	assign romrw_en = cfg.romrw_en;
	assign set_nmi  = cfg.set_nmi;

	io_strobes u_strobes (
		.zclk   (zclk),
		.rst_n  (rst_n),
		.iorq_n (iorq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.strb   (strb)
	);

	port_decoder u_decoder (
		.a             (a),
		.dos           (dos),
		.cfg           (cfg),
		.sel           (sel),
		.porthit       (porthit),
		.external_port (external_port),
		.shadow        (shadow)
	);

	paging_regs u_paging (
		.zclk          (zclk),
		.rst_n         (rst_n),
		.din           (din),
		.strb          (strb),
		.sel           (sel),
		.pg            (pg),
		.p7ffd         (p7ffd),
		.peff7         (peff7),
		.pent1m_page   (pent1m_page),
		.pent1m_rom    (pent1m_rom),
		.pent1m_1m_on  (pent1m_1m_on),
		.pent1m_ram0_0 (pent1m_ram0_0)
	);

	system_regs u_sys (
		.zclk      (zclk),
		.rst_n     (rst_n),
		.din       (din),
		.a         (a),
		.strb      (strb),
		.sel       (sel),
		.cfg       (cfg),
		.border    (border),
		.beeper_wr (beeper_wr),
		.clr_nmi   (clr_nmi)
	);

	read_mux u_rdmux (
		.a         (a),
		.shadow    (shadow),
		.keys_in   (keys_in),
		.tape_read (tape_read),
		.kj_in     (kj_in),
		.mus_in    (mus_in),
		.cfg       (cfg),
		.pg        (pg),
		.dout      (dout)
	);

endmodule

// File: test/tb_zports.sv
/* testbench of the z80 io port block
   drives io cycles, keeps a register model, checks with assertions */
module tb_zports;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_HALF    = 2;
	localparam int RST_CYCLES  = 5;
	localparam int N_BORDER    = 8;  // random FE/F6 writes
	localparam int N_PAGE      = 12; // random 7FFD/EFF7 writes
	localparam int N_FIXED     = 23; // directed accesses
	localparam int N_ACCESS    = 1 + N_BORDER + N_PAGE + N_FIXED;
	localparam int WATCHDOG_NS = (RST_CYCLES + N_ACCESS * 5 + 50) * 2 * CLK_HALF;

	logic zclk, rst_n, iorq_n, rd_n, wr_n, dos, tape_read;
	zports_pkg::addr_t a;
	zports_pkg::data_t din, mus_in, dout, p7ffd, peff7;
	logic [4:0] keys_in, kj_in;
	logic [3:0] border;
	logic [5:0] pent1m_page;
	logic dataout, porthit, external_port, ay_bdir, ay_bc1, beeper_wr, clr_nmi;
	logic romrw_en, set_nmi, pent1m_rom, pent1m_1m_on, pent1m_ram0_0;

	// register model
	logic [7:0] m_7ffd, m_eff7;
	logic [3:0] m_border;
	logic       m_shadow_en, m_romrw_en, m_set_nmi;
	int         exp_beep, exp_nmi, beep_cnt, nmi_cnt;
	logic       beep_prev, nmi_prev;
	logic [31:0] rng_state = 32'd4;

	zports uut (.*);

	always #(CLK_HALF) zclk = ~zclk; // 4 ns period

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp)
		else
			fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13); // xorshift32
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = next_rand();
		return r[7:0];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// reference rules
	function automatic logic exp_hit(input logic [15:0] addr);
		logic [7:0] lo;
		logic       shd;
		lo  = addr[7:0];
		shd = dos | m_shadow_en;
		return lo == 8'hFE || lo == 8'hF6 || lo == 8'hFD || lo == 8'hBF || lo == 8'hBE ||
			lo == 8'hDF || (lo == 8'h1F && !shd) || (lo == 8'hF7 && (addr[8] != shd));
	endfunction

	function automatic logic [7:0] exp_dout(input logic [15:0] addr);
		logic [7:0] lo;
		lo = addr[7:0];
		if (lo == 8'hFE || lo == 8'hF6)
			return {1'b1, tape_read, 1'b0, keys_in};
		if (lo == 8'h1F && !(dos | m_shadow_en))
			return {3'b000, kj_in};
		if (lo == 8'hDF)
			return mus_in;
		if (lo == 8'hBF)
			return {5'b00000, m_set_nmi, m_romrw_en, m_shadow_en};
		if (lo == 8'hBE && addr[12:8] == 5'h0A)
			return m_7ffd; // raw value, no masking
		if (lo == 8'hBE && addr[12:8] == 5'h0B)
			return m_eff7;
		return 8'hFF;
	endfunction

	// model update at the edge that ends the write strobe
	task automatic apply_write(input logic [15:0] addr, input logic [7:0] data);
		logic [7:0] lo;
		lo = addr[7:0];
		if (lo == 8'hFE || lo == 8'hF6)
			m_border = {~addr[3], data[2:0]};
		if (lo == 8'hFE)
			exp_beep++;
		if (lo == 8'hFD && !addr[15] && !(m_7ffd[5] && m_eff7[2]))
			m_7ffd = data; // 48k lock
		if (lo == 8'hF7 && !addr[12] && addr[8] && !(dos | m_shadow_en))
			m_eff7 = data;
		if (lo == 8'hBF)
		begin
			m_shadow_en = data[0];
			m_romrw_en  = data[1];
			m_set_nmi   = data[3];
		end
		if (lo == 8'hBE)
			exp_nmi++;
	endtask

	task automatic check_regs();
		check_eq("p7ffd", p7ffd, m_eff7[2] ? {3'b000, m_7ffd[4:0]} : m_7ffd);
		check_eq("peff7", peff7, m_eff7[2] ? (m_eff7 & 8'hB1) : m_eff7);
		check_eq("pent1m_page", pent1m_page, {m_7ffd[7:5], m_7ffd[2:0]});
		check_eq("pent1m_rom", pent1m_rom, m_7ffd[4]);
		check_eq("pent1m_1m_on", pent1m_1m_on, !m_eff7[2]);
		check_eq("pent1m_ram0_0", pent1m_ram0_0, m_eff7[3]);
		check_eq("border", border, m_border);
		check_eq("romrw_en", romrw_en, m_romrw_en);
		check_eq("set_nmi", set_nmi, m_set_nmi);
	endtask

	//////////////////////////////////////////////////////////////////////
	// bus cycle, 3 cycles active then 2 idle
	task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] data, input logic is_wr);
		logic [31:0] r;
		r = next_rand();
		{keys_in, kj_in, tape_read} = r[10:0]; // fresh read inputs
		mus_in = r[18:11];
		a      = addr;
		din    = data;
		iorq_n = 1'b0;
		wr_n   = ~is_wr;
		rd_n   = is_wr;
		repeat (2) @(posedge zclk);
		#1;
		if (is_wr)
		begin
			apply_write(addr, data); // registers settled two edges in
			check_regs();
		end
		@(posedge zclk);
		#1;
		{iorq_n, rd_n, wr_n} = 3'b111;
		repeat (2) @(posedge zclk);
		#1;
		check_eq("beeper_wr count", beep_cnt, exp_beep);
		check_eq("clr_nmi count", nmi_cnt, exp_nmi);
	endtask

	// combinational outputs and pulses, sampled mid cycle
	always @(negedge zclk)
	begin
		if (rst_n)
		begin
			check_eq("porthit", porthit, exp_hit(a));
			check_eq("external_port", external_port, a[7:0] == 8'hFD && a[15]);
			check_eq("dataout", dataout, exp_hit(a) && !iorq_n && !rd_n &&
				!(a[7:0] == 8'hFD && a[15]));
			check_eq("ay_bdir", ay_bdir, a[7:0] == 8'hFD && a[15] && !iorq_n && !wr_n);
			check_eq("ay_bc1", ay_bc1, a[7:0] == 8'hFD && a[15] && a[14] && !iorq_n &&
				!(rd_n && wr_n));
			if (!iorq_n && !rd_n)
				check_eq("dout", dout, exp_dout(a));
			assert (!(beeper_wr && beep_prev))
			else
				fail_run("beeper_wr stayed high for more than one cycle");
			assert (!(clr_nmi && nmi_prev))
			else
				fail_run("clr_nmi stayed high for more than one cycle");
			beep_cnt += beeper_wr;
			nmi_cnt  += clr_nmi;
		end
		beep_prev = beeper_wr;
		nmi_prev  = clr_nmi;
	end

	initial
	begin
		#(WATCHDOG_NS);
		fail_run("watchdog expired before the test sequence finished");
	end

	initial
	begin
		logic [7:0] d;
		{zclk, rst_n, iorq_n, rd_n, wr_n, dos} = 6'b001110;
		{a, din, mus_in, keys_in, kj_in, tape_read} = '0;
		{m_7ffd, m_eff7, m_border, m_shadow_en, m_romrw_en, m_set_nmi} = '0;
		{exp_beep, exp_nmi, beep_cnt, nmi_cnt} = '0;
		{beep_prev, nmi_prev} = 2'b00;
		repeat (RST_CYCLES) @(posedge zclk);
		#1;
		rst_n = 1'b1;
		check_regs();
		bus_cycle(16'h00FE, 8'h00, 1'b0); // keyboard read after reset

		// border and beeper
		for (int i = 0; i < N_BORDER; i++)
			bus_cycle({rand_byte(), (i % 2) ? 8'hF6 : 8'hFE}, rand_byte(), 1'b1);

		// paging, random then lock
		for (int i = 0; i < N_PAGE; i++)
			bus_cycle((i % 3) ? 16'h7FFD : 16'hEFF7, rand_byte(), 1'b1);
		bus_cycle(16'hEFF7, 8'h00, 1'b1);
		bus_cycle(16'h7FFD, 8'h35, 1'b1);
		d = rand_byte();
		bus_cycle(16'hEFF7, (d & 8'hFB) | 8'h04, 1'b1);
		bus_cycle(16'h7FFD, rand_byte() | 8'h80, 1'b1); // locked, no change
		bus_cycle(16'hEFF7, 8'h00, 1'b1);

		// config register and shadow mode
		bus_cycle(16'h00BF, 8'h0B, 1'b1);
		bus_cycle(16'h00BF, 8'h00, 1'b0);
		bus_cycle(16'h001F, 8'h00, 1'b0);
		bus_cycle(16'hEFF7, 8'h5A, 1'b1); // ignored in shadow
		bus_cycle(16'hEEF7, 8'h00, 1'b0);
		bus_cycle(16'h00BF, 8'h00, 1'b1);
		dos = 1'b1;
		bus_cycle(16'h001F, 8'h00, 1'b0);
		bus_cycle(16'hEFF7, 8'hA5, 1'b1);
		dos = 1'b0;
		bus_cycle(16'h001F, 8'h00, 1'b0);
		bus_cycle(16'h00BE, 8'h00, 1'b1); // nmi clear

		// readback
		bus_cycle(16'h7FFD, rand_byte(), 1'b1);
		bus_cycle(16'hEFF7, rand_byte(), 1'b1);
		bus_cycle(16'h0ABE, 8'h00, 1'b0);
		bus_cycle(16'h0BBE, 8'h00, 1'b0);
		bus_cycle(16'h00BE, 8'h00, 1'b0);

		// ay chip
		bus_cycle(16'hFFFD, 8'h07, 1'b1);
		bus_cycle(16'hBFFD, 8'h3C, 1'b1);
		bus_cycle(16'hFFFD, 8'h00, 1'b0);

		$display("Test OK");
		$finish;
	end

endmodule

// File: tb.f
source/zports_pkg.sv
source/io_strobes.sv
source/port_decoder.sv
source/paging_regs.sv
source/system_regs.sv
source/read_mux.sv
source/zports.sv
test/tb_zports.sv

// File: Bender.yml
package:
  name: zports

sources:
  - source/zports_pkg.sv
  - source/io_strobes.sv
  - source/port_decoder.sv
  - source/paging_regs.sv
  - source/system_regs.sv
  - source/read_mux.sv
  - source/zports.sv
  - target: test
    files:
      - test/tb_zports.sv
